// File: Bender.yml
package:
  name: sys_io

sources:
  - design/hostio_pkg.sv
  - design/audio_pkg.sv
  - design/hps_io_sync.sv
  - design/uio_control.sv
  - design/audio_mix_channel.sv
  - design/sys_io_top.sv
  - target: test
    files:
      - testbench/tb_sys_io.sv

// File: build.f
design/hostio_pkg.sv
design/audio_pkg.sv
design/hps_io_sync.sv
design/uio_control.sv
design/audio_mix_channel.sv
design/sys_io_top.sv
testbench/tb_sys_io.sv

// File: design/audio_mix_channel.sv
`timescale 1ns/10ps
`default_nettype none

module audio_mix_channel
	import hostio_pkg::*;
	import audio_pkg::*;
(
	input  logic                clk,
	input  logic                resetd,
	input  logic [VOL_ATT_W-1:0] i_att,
	input  mix_mode_t           i_mix,
	input  logic                i_signed,
	input  logic [SAMPLE_W-1:0] i_core,
	input  logic [SAMPLE_W-1:0] i_linux,
	input  logic [SAMPLE_W-1:0] i_pre,
	output logic [SAMPLE_W-1:0] o_pre,
	output logic [SAMPLE_W-1:0] o_out
);

	logic        [SAMPLE_W-1:0] d1;
	logic        [SAMPLE_W-1:0] d2;
	logic        [SAMPLE_W-1:0] d3;
	logic        [SAMPLE_W-1:0] ca;

	logic signed [ACC_W-1:0]    a1;
	logic signed [ACC_W-1:0]    a2;
	logic signed [ACC_W-1:0]    a3;
	logic signed [ACC_W-1:0]    lin_ext;
	logic signed [ACC_W-1:0]    pre_ext;
	logic signed [ACC_W-1:0]    a4;

	assign lin_ext = {{(ACC_W-SAMPLE_W){i_linux[SAMPLE_W-1]}}, i_linux};
	assign pre_ext = {{(ACC_W-SAMPLE_W){i_pre[SAMPLE_W-1]}}, i_pre};

	////////////////////
	// Glitch filter
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			d3 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			// Three matching samples in a row before it is taken
			if (d1 == d2 && d2 == d3)
				ca <= d3;
		end
	end

	////////////////////
	// Mix pipeline
	////////////////////

	// Attenuate or mute, ahead of the clamp register
	always_comb begin
		if (i_att[MUTE_BIT])
			a4 = '0;
		else
			a4 = a3 >>> i_att[ATT_SHIFT_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Unsigned samples drop to half scale around zero
			if (i_signed)
				a1 <= {ca[SAMPLE_W-1], ca};
			else
				a1 <= {2'b00, ca[SAMPLE_W-1:1]};

			a2 <= a1 + lin_ext;

			// Half of the sum goes across to the other channel
			o_pre <= a2[ACC_W-1:1];

			case (i_mix)
				MIX_NONE: a3 <= a2;
				MIX_25:   a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
				MIX_50:   a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
				MIX_MONO: a3 <= (a2 >>> 1) + pre_ext;
				default:  a3 <= a2;
			endcase

			// Saturate to 16 bits when the top two bits disagree
			if (a4[ACC_W-1] != a4[ACC_W-2])
				o_out <= {a4[ACC_W-1], {(SAMPLE_W-1){~a4[ACC_W-1]}}};
			else
				o_out <= a4[SAMPLE_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: design/audio_pkg.sv
`default_nettype none

package audio_pkg;

	////////////////////
	// Sample widths
	////////////////////

	localparam int SAMPLE_W = 16;

	// One extra bit of headroom for core plus Linux stream
	localparam int ACC_W = 17;

	// Crossfeed strength between left and right
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_t;

	// Attenuation field, mute on top and shift count below it
	localparam int MUTE_BIT    = 4;
	localparam int ATT_SHIFT_W = 4;

endpackage

`default_nettype wire

// File: design/hostio_pkg.sv
`default_nettype none

package hostio_pkg;

	////////////////////
	// Host word layout
	////////////////////

	localparam int HOST_WORD_W = 32;
	localparam int IO_DATA_W   = 16;

	// Strobe clock and selects inside the host word
	localparam int IO_CLK_BIT = 17;
	localparam int IO_SS0_BIT = 18;
	localparam int IO_SS1_BIT = 19;
	localparam int IO_SS2_BIT = 20;

	// Select vector as passed downstream, {ss2, ss1, ss0}
	localparam int IO_SS_W = 3;

	// User-I/O channel is ss2 high with ss1 low, ss0 is don't care
	localparam logic [IO_SS_W-1:0] UIO_SEL_MASK = 3'b110;
	localparam logic [IO_SS_W-1:0] UIO_SEL_CODE = 3'b100;

	////////////////////
	// Commands
	////////////////////

	typedef enum logic [7:0] {
		CMD_CFG = 8'h01,
		CMD_LED = 8'h25,
		CMD_VOL = 8'h26
	} uio_cmd_t;

	// Board LED bus and where the live status bits sit on it
	localparam int LED_W        = 8;
	localparam int LED_PWR_BIT  = 4;
	localparam int LED_DISK_BIT = 2;
	localparam int LED_USER_BIT = 0;

	localparam int VOL_ATT_W = 5;

endpackage

`default_nettype wire

// File: design/hps_io_sync.sv
`timescale 1ns/10ps
`default_nettype none

module hps_io_sync
	import hostio_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetd,
	input  logic [HOST_WORD_W-1:0] i_gp_out,
	input  logic                   i_io_wait,
	output logic [IO_DATA_W-1:0]   o_io_din,
	output logic [IO_SS_W-1:0]     o_io_ss,
	output logic                   o_io_strobe,
	output logic                   o_io_ack
);

	logic [HOST_WORD_W-1:0] gp_d;
	logic [HOST_WORD_W-1:0] gp_r;
	logic                   io_clk;
	logic                   rack;

	// Two register stages on the host word
	always_ff @(posedge clk) begin
		if (resetd) begin
			gp_d <= '0;
			gp_r <= '0;
		end else begin
			gp_d <= i_gp_out;
			gp_r <= gp_d;
		end
	end

	assign io_clk   = gp_r[IO_CLK_BIT];
	assign o_io_din = gp_r[IO_DATA_W-1:0];
	assign o_io_ss  = {gp_r[IO_SS2_BIT], gp_r[IO_SS1_BIT], gp_r[IO_SS0_BIT]};

	// High for the first cycle of a new I/O clock level
	assign o_io_strobe = io_clk & ~rack;

	// Core wait freezes the ack, but never across a pending strobe
	always_ff @(posedge clk) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else if (!i_io_wait || o_io_strobe) begin
			rack     <= io_clk;
			o_io_ack <= rack;
		end
	end

endmodule

`default_nettype wire

// File: design/sys_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module sys_io_top
	import hostio_pkg::*;
	import audio_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetd,

	input  logic [HOST_WORD_W-1:0] i_gp_out,
	input  logic                   i_io_wait,
	output logic                   o_io_ack,

	input  logic [1:0]             i_led_power,
	input  logic [1:0]             i_led_disk,
	input  logic                   i_led_user,
	output logic [IO_DATA_W-1:0]   o_cfg,
	output logic [LED_W-1:0]       o_led,

	input  logic [SAMPLE_W-1:0]    i_core_l,
	input  logic [SAMPLE_W-1:0]    i_core_r,
	input  logic [SAMPLE_W-1:0]    i_alsa_l,
	input  logic [SAMPLE_W-1:0]    i_alsa_r,
	input  logic                   i_audio_signed,
	input  mix_mode_t              i_audio_mix,
	output logic [SAMPLE_W-1:0]    o_audio_l,
	output logic [SAMPLE_W-1:0]    o_audio_r
);

	logic [IO_DATA_W-1:0] io_din;
	logic [IO_SS_W-1:0]   io_ss;
	logic                 io_strobe;
	logic [VOL_ATT_W-1:0] vol_att;
	logic [SAMPLE_W-1:0]  pre_l;
	logic [SAMPLE_W-1:0]  pre_r;

	////////////////////
	// Host channel
	////////////////////

	hps_io_sync u_sync (
		.clk         (clk),
		.resetd      (resetd),
		.i_gp_out    (i_gp_out),
		.i_io_wait   (i_io_wait),
		.o_io_din    (io_din),
		.o_io_ss     (io_ss),
		.o_io_strobe (io_strobe),
		.o_io_ack    (o_io_ack)
	);

	uio_control u_uio (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_din    (io_din),
		.i_io_ss     (io_ss),
		.i_io_strobe (io_strobe),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.i_led_user  (i_led_user),
		.o_cfg       (o_cfg),
		.o_vol_att   (vol_att),
		.o_led       (o_led)
	);

	////////////////////
	// Audio
	////////////////////

	// Each side gets the other's half-scale sum for crossfeed
	audio_mix_channel mix_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_att    (vol_att),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_core   (i_core_l),
		.i_linux  (i_alsa_l),
		.i_pre    (pre_r),
		.o_pre    (pre_l),
		.o_out    (o_audio_l)
	);

	audio_mix_channel mix_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_att    (vol_att),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_core   (i_core_r),
		.i_linux  (i_alsa_r),
		.i_pre    (pre_l),
		.o_pre    (pre_r),
		.o_out    (o_audio_r)
	);

endmodule

`default_nettype wire

// File: design/uio_control.sv
`timescale 1ns/10ps
`default_nettype none

module uio_control
	import hostio_pkg::*;
(
	input  logic                 clk,
	input  logic                 resetd,
	input  logic [IO_DATA_W-1:0] i_io_din,
	input  logic [IO_SS_W-1:0]   i_io_ss,
	input  logic                 i_io_strobe,
	input  logic [1:0]           i_led_power,
	input  logic [1:0]           i_led_disk,
	input  logic                 i_led_user,
	output logic [IO_DATA_W-1:0] o_cfg,
	output logic [VOL_ATT_W-1:0] o_vol_att,
	output logic [LED_W-1:0]     o_led
);

	logic                 stb_d;
	logic                 stb_dd;
	logic                 uio_d;
	logic [IO_DATA_W-1:0] din_d;
	logic                 stb_rise;

	logic                 has_cmd;
	uio_cmd_t             cmd;
	logic [LED_W-1:0]     led_mask;
	logic [LED_W-1:0]     led_state;

	logic                 led_p;
	logic                 led_d;
	logic [LED_W-1:0]     led_status;

	////////////////////
	// Input stage
	////////////////////

	// Strobe, data and channel select retimed together
	always_ff @(posedge clk) begin
		if (resetd) begin
			stb_d  <= 1'b0;
			stb_dd <= 1'b0;
			uio_d  <= 1'b0;
			din_d  <= '0;
		end else begin
			stb_d  <= i_io_strobe;
			stb_dd <= stb_d;
			uio_d  <= (i_io_ss & UIO_SEL_MASK) == UIO_SEL_CODE;
			din_d  <= i_io_din;
		end
	end

	assign stb_rise = stb_d & ~stb_dd;

	////////////////////
	// Command decoder
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= uio_cmd_t'(8'h00);
			o_cfg     <= '0;
			o_vol_att <= '0;
			led_mask  <= '0;
			led_state <= '0;
		end else if (!uio_d) begin
			// Next transfer starts with a command word
			has_cmd <= 1'b0;
			cmd     <= uio_cmd_t'(8'h00);
		end else if (stb_rise) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= uio_cmd_t'(din_d[7:0]);
			end else begin
				case (cmd)
					CMD_CFG: o_cfg <= din_d;
					CMD_LED: begin
						led_mask  <= din_d[IO_DATA_W-1 -: LED_W];
						led_state <= din_d[LED_W-1:0];
					end
					CMD_VOL: o_vol_att <= din_d[VOL_ATT_W-1:0];
					// Opcodes not handled here are dropped
					default: ;
				endcase
			end
		end
	end

	////////////////////
	// Board LEDs
	////////////////////

	// Power on only for code 2'b10, disk for either single bit
	assign led_p = i_led_power[1] & ~i_led_power[0];
	assign led_d = i_led_disk[1] ^ i_led_disk[0];

	always_comb begin
		led_status               = '0;
		led_status[LED_PWR_BIT]  = led_p;
		led_status[LED_DISK_BIT] = led_d;
		led_status[LED_USER_BIT] = i_led_user;
	end

	// Host override wins bit by bit
	assign o_led = (led_mask & led_state) | (~led_mask & led_status);

endmodule

`default_nettype wire

// File: testbench/tb_sys_io.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sys_io
	import hostio_pkg::*;
	import audio_pkg::*;
();

	localparam int RESET_CYCLES  = 10;
	localparam int N_SEQ         = 40;
	localparam int MAX_DATA      = 4;
	localparam int N_LED         = 12;
	localparam int N_BP          = 4;
	localparam int N_AUDIO       = 24;
	localparam int ACK_LIMIT     = 16;
	localparam int HOLD_CYCLES   = 8;
	localparam int SETTLE_CYCLES = 12;

	// Worst-case cycles for one host word or one audio sample
	localparam int WORD_BOUND   = 40;
	localparam int SAMPLE_BOUND = 40;
	localparam int N_WORDS      = N_SEQ * (MAX_DATA + 2) + N_LED * 4 + N_BP * 5 + N_AUDIO * 3;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 + N_WORDS * WORD_BOUND
		+ N_AUDIO * 2 * SAMPLE_BOUND;

	logic                   clk = 1'b0;
	logic                   resetd;
	logic [HOST_WORD_W-1:0] i_gp_out;
	logic                   i_io_wait;
	logic                   o_io_ack;
	logic [1:0]             i_led_power;
	logic [1:0]             i_led_disk;
	logic                   i_led_user;
	logic [IO_DATA_W-1:0]   o_cfg;
	logic [LED_W-1:0]       o_led;
	logic [SAMPLE_W-1:0]    i_core_l;
	logic [SAMPLE_W-1:0]    i_core_r;
	logic [SAMPLE_W-1:0]    i_alsa_l;
	logic [SAMPLE_W-1:0]    i_alsa_r;
	logic                   i_audio_signed;
	mix_mode_t              i_audio_mix;
	logic [SAMPLE_W-1:0]    o_audio_l;
	logic [SAMPLE_W-1:0]    o_audio_r;

	logic [31:0]            rng_state = 32'd80615;
	int                     n_checks = 0;
	int                     n_errors = 0;

	// Reference copy of the decoder registers
	logic [IO_DATA_W-1:0]   exp_cfg;
	logic [LED_W-1:0]       exp_mask;
	logic [LED_W-1:0]       exp_state;
	logic [VOL_ATT_W-1:0]   exp_att;

	always #50 clk = ~clk;

	sys_io_top dut (.*);

	////////////////////
	// Model
	////////////////////

	// Two LCG steps, upper halves only
	function automatic logic [31:0] rand32();
		logic [31:0] hi;
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		hi = rng_state;
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return {hi[31:16], rng_state[31:16]};
	endfunction

	// Bits 20:18 selects, 17 I/O clock, 15:0 data
	function automatic logic [HOST_WORD_W-1:0] host_word(input logic [IO_DATA_W-1:0] data,
		input logic [IO_SS_W-1:0] ss, input logic io_clk);
		return {11'd0, ss, io_clk, 1'b0, data};
	endfunction

	function automatic logic [LED_W-1:0] expected_led(input logic [LED_W-1:0] mask,
		input logic [LED_W-1:0] state, input logic [1:0] pwr, input logic [1:0] disk,
		input logic user);
		logic [LED_W-1:0] led;
		led    = '0;
		led[4] = (pwr == 2'b10);
		led[2] = (disk == 2'b10) || (disk == 2'b01);
		led[0] = user;
		for (int i = 0; i < LED_W; i++)
			if (mask[i])
				led[i] = state[i];
		return led;
	endfunction

	// Core plus Linux sample before crossfeed
	function automatic int mix_sum(input logic [SAMPLE_W-1:0] core,
		input logic [SAMPLE_W-1:0] lin, input logic sgn);
		int c;
		if (sgn)
			c = $signed(core);
		else
			c = core >> 1;
		return c + $signed(lin);
	endfunction

	function automatic int mix_expect(input int a, input int pre_other, input mix_mode_t m,
		input logic [VOL_ATT_W-1:0] att);
		int v;
		case (m)
			MIX_NONE: v = a;
			MIX_25:   v = a - (a >>> 3) + (pre_other >>> 2);
			MIX_50:   v = a - (a >>> 2) + (pre_other >>> 1);
			default:  v = (a >>> 1) + pre_other;
		endcase
		if (att[MUTE_BIT])
			v = 0;
		else
			v = v >>> att[ATT_SHIFT_W-1:0];
		if (v > 32767)
			v = 32767;
		if (v < -32768)
			v = -32768;
		return v;
	endfunction

	task automatic model_word(input logic [7:0] op, input logic [IO_DATA_W-1:0] data);
		case (op)
			CMD_CFG: exp_cfg = data;
			CMD_LED: begin
				exp_mask  = data[15:8];
				exp_state = data[7:0];
			end
			CMD_VOL: exp_att = data[VOL_ATT_W-1:0];
			default: ;
		endcase
	endtask

	////////////////////
	// Host side
	////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		n_errors++;
	endtask

	// One I/O clock phase, optionally with the core wait held for a while
	task automatic handshake(input logic [IO_DATA_W-1:0] data, input logic [IO_SS_W-1:0] ss,
		input logic lvl, input int hold);
		int n;
		int limit;
		limit = (hold > 0) ? 4 : ACK_LIMIT;
		@(posedge clk);
		i_gp_out  <= host_word(data, ss, lvl);
		i_io_wait <= (hold > 0);
		repeat (hold) begin
			@(negedge clk);
			n_checks++;
			if (o_io_ack !== !lvl)
				report_mismatch("o_io_ack", o_io_ack, !lvl);
		end
		if (hold > 0) begin
			@(posedge clk);
			i_io_wait <= 1'b0;
		end
		n = 0;
		@(negedge clk);
		while (o_io_ack !== lvl && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (o_io_ack !== lvl) begin
			$display("ERROR t=%0t no acknowledge at level %0d after %0d cycles", $time, lvl, n);
			n_errors++;
		end
	endtask

	task automatic send_word(input logic [IO_DATA_W-1:0] data, input int hold);
		logic [31:0] r;
		r = rand32();
		// ss0 is free while the user-I/O channel is selected
		handshake(data, {2'b10, r[7]}, 1'b1, hold);
		handshake(data, {2'b10, r[7]}, 1'b0, hold);
	endtask

	task automatic deselect();
		@(posedge clk);
		i_gp_out <= host_word(16'h0000, 3'b010, 1'b0);
		repeat (6) @(posedge clk);
	endtask

	task automatic randomize_status();
		logic [31:0] r;
		r = rand32();
		@(posedge clk);
		i_led_power <= r[1:0];
		i_led_disk  <= r[3:2];
		i_led_user  <= r[4];
	endtask

	task automatic check_regs();
		logic [LED_W-1:0] led;
		led = expected_led(exp_mask, exp_state, i_led_power, i_led_disk, i_led_user);
		n_checks += 2;
		if (o_cfg !== exp_cfg)
			report_mismatch("o_cfg", o_cfg, exp_cfg);
		if (o_led !== led)
			report_mismatch("o_led", o_led, led);
	endtask

	task automatic check_audio(input int exp_l, input int exp_r);
		n_checks += 2;
		if (o_audio_l !== 16'(exp_l))
			report_mismatch("o_audio_l", o_audio_l, 16'(exp_l));
		if (o_audio_r !== 16'(exp_r))
			report_mismatch("o_audio_r", o_audio_r, 16'(exp_r));
	endtask

	////////////////////
	// Tests
	////////////////////

	initial begin
		int                   err_start;
		int                   n_data;
		int                   a_l;
		int                   a_r;
		int                   e_l;
		int                   e_r;
		logic [31:0]          r;
		logic [7:0]           op;
		logic [IO_DATA_W-1:0] data;
		logic [VOL_ATT_W-1:0] att;
		logic [SAMPLE_W-1:0]  core_l;
		logic [SAMPLE_W-1:0]  core_r;

		resetd         <= 1'b1;
		i_gp_out       <= '0;
		i_io_wait      <= 1'b0;
		i_led_power    <= '0;
		i_led_disk     <= '0;
		i_led_user     <= 1'b0;
		i_core_l       <= '0;
		i_core_r       <= '0;
		i_alsa_l       <= '0;
		i_alsa_r       <= '0;
		i_audio_signed <= 1'b0;
		i_audio_mix    <= MIX_NONE;
		exp_cfg   = '0;
		exp_mask  = '0;
		exp_state = '0;
		exp_att   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		resetd <= 1'b0;

		err_start = n_errors;
		repeat (2) @(negedge clk);
		n_checks += 3;
		if (o_io_ack !== 1'b0)
			report_mismatch("o_io_ack", o_io_ack, 0);
		if (o_audio_l !== '0)
			report_mismatch("o_audio_l", o_audio_l, 0);
		if (o_audio_r !== '0)
			report_mismatch("o_audio_r", o_audio_r, 0);
		check_regs();
		$display("Test reset done, %0d errors", n_errors - err_start);

		// Random command streams, unknown opcodes included
		err_start = n_errors;
		for (int s = 0; s < N_SEQ; s++) begin
			randomize_status();
			case (rand32() % 4)
				0: op = CMD_CFG;
				1: op = CMD_LED;
				2: op = CMD_VOL;
				default: begin
					op = 8'(rand32());
					if (op == CMD_CFG || op == CMD_LED || op == CMD_VOL)
						op = 8'h7f;
				end
			endcase
			send_word({8'(rand32()), op}, 0);
			n_data = 1 + int'(rand32() % MAX_DATA);
			for (int w = 0; w < n_data; w++) begin
				data = 16'(rand32());
				send_word(data, 0);
				model_word(op, data);
				check_regs();
			end
			deselect();
		end
		$display("Test command sequences done, %0d errors", n_errors - err_start);

		err_start = n_errors;
		for (int k = 0; k < N_LED; k++) begin
			send_word({8'h00, CMD_LED}, 0);
			data = 16'(rand32());
			send_word(data, 0);
			model_word(CMD_LED, data);
			for (int j = 0; j < 8; j++) begin
				randomize_status();
				@(negedge clk);
				check_regs();
			end
			deselect();
		end
		$display("Test LED composition done, %0d errors", n_errors - err_start);

		// A repeated command word would show up in o_cfg
		err_start = n_errors;
		for (int k = 0; k < N_BP; k++) begin
			send_word({8'(rand32()), CMD_CFG}, HOLD_CYCLES);
			check_regs();
			data = 16'(rand32());
			send_word(data, HOLD_CYCLES);
			model_word(CMD_CFG, data);
			check_regs();
			deselect();
		end
		$display("Test back-pressure done, %0d errors", n_errors - err_start);

		err_start = n_errors;
		for (int k = 0; k < N_AUDIO; k++) begin
			r = rand32();
			// Mute, no attenuation for saturation, or a random shift
			case (r[2:0])
				3'd0: att = {1'b1, r[6:3]};
				3'd1, 3'd2, 3'd3: att = '0;
				default: att = {1'b0, r[6:3]};
			endcase
			send_word({8'h00, CMD_VOL}, 0);
			data = {r[31:21], att};
			send_word(data, 0);
			model_word(CMD_VOL, data);
			deselect();

			r      = rand32();
			core_l = 16'(rand32());
			core_r = 16'(rand32());
			data   = 16'(rand32());
			@(posedge clk);
			i_core_l       <= core_l;
			i_core_r       <= core_r;
			i_alsa_l       <= data;
			i_alsa_r       <= r[31:16];
			i_audio_signed <= r[0];
			i_audio_mix    <= mix_mode_t'(r[2:1]);
			a_l = mix_sum(core_l, data, r[0]);
			a_r = mix_sum(core_r, r[31:16], r[0]);
			e_l = mix_expect(a_l, a_r >>> 1, mix_mode_t'(r[2:1]), exp_att);
			e_r = mix_expect(a_r, a_l >>> 1, mix_mode_t'(r[2:1]), exp_att);
			repeat (SETTLE_CYCLES) @(negedge clk);
			check_audio(e_l, e_r);

			// Single-cycle spike on both core inputs
			@(posedge clk);
			i_core_l <= core_l ^ 16'(rand32() | 1);
			i_core_r <= core_r ^ 16'h8000;
			@(posedge clk);
			i_core_l <= core_l;
			i_core_r <= core_r;
			for (int j = 0; j < SETTLE_CYCLES; j++) begin
				@(negedge clk);
				check_audio(e_l, e_r);
			end
		end
		$display("Test audio mixer done, %0d errors", n_errors - err_start);

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR t=%0t watchdog expired after %0d cycles", $time, WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
